// ==== pwm_config.svh ====
`ifndef PWM_CONFIG_SVH
`define PWM_CONFIG_SVH

// Counter and compare value width
`define PWM_COUNTER_WIDTH 16

`define PWM_N_CHANNELS 3

`define PWM_BASE_ADDRESS 32'h0000_0000

// Register offsets from the base address
`define PWM_REG_CMP_LOW0  32'h00
`define PWM_REG_CMP_LOW1  32'h04
`define PWM_REG_CMP_LOW2  32'h08
`define PWM_REG_CMP_HIGH0 32'h0C
`define PWM_REG_CMP_HIGH1 32'h10
`define PWM_REG_CMP_HIGH2 32'h14
`define PWM_REG_DEADTIME0 32'h18
`define PWM_REG_DEADTIME1 32'h1C
`define PWM_REG_DEADTIME2 32'h20
`define PWM_REG_START     32'h24
`define PWM_REG_STOP      32'h28
`define PWM_REG_SHIFT     32'h2C
`define PWM_REG_OUT_EN    32'h30
`define PWM_REG_DT_EN     32'h34
`define PWM_REG_CONTROL   32'h38

`endif

// ==== pwm_pkg.sv ====
package pwm_pkg;

    // Unlisted codes count up
    typedef enum logic [2:0] {
        count_up     = 3'd0,
        count_down   = 3'd1,
        count_updown = 3'd2
    } counter_mode_t;

    // 0-2 low thresholds, 3-5 high thresholds, 6 duty bottom, 7 duty top
    typedef logic [2:0] compare_index_t;

endpackage

// ==== pwm_chain_control.sv ====
`include "pwm_config.svh"

module pwm_chain_control (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          write_strobe,
    input  logic [31:0]                   address,
    input  logic [31:0]                   write_data,
    input  logic                          counter_running,
    output logic                          ready,
    output logic                          counter_run,
    output pwm_pkg::counter_mode_t        counter_mode,
    output logic [`PWM_COUNTER_WIDTH-1:0] start_value,
    output logic [`PWM_COUNTER_WIDTH-1:0] stop_value,
    output logic [15:0]                   timebase_shift,
    output logic                          compare_write_strobe,
    output pwm_pkg::compare_index_t       compare_address,
    output logic [`PWM_COUNTER_WIDTH-1:0] compare_data,
    output logic [15:0]                   deadtime [`PWM_N_CHANNELS],
    output logic                          deadtime_enable [`PWM_N_CHANNELS],
    output logic [1:0]                    output_enable [`PWM_N_CHANNELS]
);
    import pwm_pkg::*;

    typedef enum logic {
        idle_state,
        act_state
    } state_t;

    state_t                        state;
    logic                          act_done;
    logic                          dc_mode;
    logic [`PWM_COUNTER_WIDTH-1:0] dc_top_value;
    logic [31:0]                   latched_address;
    logic [31:0]                   latched_data;
    logic [31:0]                   offset;
    logic [`PWM_COUNTER_WIDTH-1:0] data_value;

    assign offset = latched_address - `PWM_BASE_ADDRESS;
    assign data_value = latched_data[`PWM_COUNTER_WIDTH-1:0];

    // Capture the write on the accepting edge
    always_ff @(posedge clock) begin
        if (write_strobe && ready) begin
            latched_address <= address;
            latched_data <= write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle_state;
            ready <= 1'b1;
            act_done <= 1'b0;
            dc_mode <= 1'b0;
            dc_top_value <= '1;
            counter_run <= 1'b0;
            counter_mode <= count_up;
            start_value <= '0;
            stop_value <= '0;
            timebase_shift <= '0;
            compare_write_strobe <= 1'b0;
            compare_address <= '0;
            compare_data <= '0;
            for (int i = 0; i < `PWM_N_CHANNELS; i++) begin
                deadtime[i] <= '0;
                deadtime_enable[i] <= 1'b0;
                output_enable[i] <= 2'b00;
            end
        end else begin
            compare_write_strobe <= 1'b0;
            case (state)
                idle_state: begin
                    if (write_strobe) begin
                        ready <= 1'b0;
                        state <= act_state;
                    end
                end
                act_state: begin
                    if (act_done) begin
                        // Second act cycle only releases the bus
                        act_done <= 1'b0;
                        ready <= 1'b1;
                        state <= idle_state;
                    end else begin
                        act_done <= 1'b1;
                        case (offset)
                            `PWM_REG_CMP_LOW0, `PWM_REG_CMP_LOW1, `PWM_REG_CMP_LOW2: begin
                                compare_write_strobe <= 1'b1;
                                compare_address <= compare_index_t'(offset[4:2]);
                                compare_data <= data_value;
                            end
                            `PWM_REG_CMP_HIGH0, `PWM_REG_CMP_HIGH1, `PWM_REG_CMP_HIGH2: begin
                                compare_write_strobe <= 1'b1;
                                compare_address <= compare_index_t'(offset[4:2]);
                                // Duty value is the distance from the top
                                if (dc_mode) begin
                                    compare_data <= dc_top_value - data_value;
                                end else begin
                                    compare_data <= data_value;
                                end
                            end
                            `PWM_REG_DEADTIME0, `PWM_REG_DEADTIME1, `PWM_REG_DEADTIME2: begin
                                for (int i = 0; i < `PWM_N_CHANNELS; i++) begin
                                    if (!counter_running &&
                                        offset == `PWM_REG_DEADTIME0 + 4 * i) begin
                                        deadtime[i] <= latched_data[15:0];
                                    end
                                end
                            end
                            `PWM_REG_START: begin
                                if (!counter_running) begin
                                    start_value <= data_value;
                                    if (dc_mode) begin
                                        compare_write_strobe <= 1'b1;
                                        compare_address <= compare_index_t'(3'd6);
                                        compare_data <= data_value;
                                    end
                                end
                            end
                            `PWM_REG_STOP: begin
                                if (!counter_running) begin
                                    stop_value <= data_value;
                                    if (dc_mode) begin
                                        compare_write_strobe <= 1'b1;
                                        compare_address <= compare_index_t'(3'd7);
                                        compare_data <= data_value;
                                        dc_top_value <= data_value;
                                    end
                                end
                            end
                            `PWM_REG_SHIFT: begin
                                if (!counter_running) begin
                                    timebase_shift <= latched_data[15:0];
                                end
                            end
                            `PWM_REG_OUT_EN: begin
                                for (int i = 0; i < `PWM_N_CHANNELS; i++) begin
                                    output_enable[i] <= latched_data[2*i +: 2];
                                end
                            end
                            `PWM_REG_DT_EN: begin
                                for (int i = 0; i < `PWM_N_CHANNELS; i++) begin
                                    deadtime_enable[i] <= latched_data[i];
                                end
                            end
                            `PWM_REG_CONTROL: begin
                                // Mode changes only with the counter stopped
                                if (!counter_running) begin
                                    if (latched_data[3]) begin
                                        counter_mode <= count_updown;
                                        dc_mode <= 1'b1;
                                    end else begin
                                        counter_mode <= counter_mode_t'(latched_data[2:0]);
                                        dc_mode <= 1'b0;
                                    end
                                end
                                counter_run <= latched_data[4];
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                default: state <= idle_state;
            endcase
        end
    end

endmodule

// ==== pwm_compare_bank.sv ====
`include "pwm_config.svh"

module pwm_compare_bank (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          write_strobe,
    input  pwm_pkg::compare_index_t       write_address,
    input  logic [`PWM_COUNTER_WIDTH-1:0] write_data,
    input  logic                          running,
    input  logic                          period_sync,
    output logic [`PWM_COUNTER_WIDTH-1:0] low_threshold [`PWM_N_CHANNELS],
    output logic [`PWM_COUNTER_WIDTH-1:0] high_threshold [`PWM_N_CHANNELS]
);
    localparam int N_COMPARE = 8;

    logic [`PWM_COUNTER_WIDTH-1:0] shadow [N_COMPARE];
    logic [`PWM_COUNTER_WIDTH-1:0] active [N_COMPARE];

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < N_COMPARE; i++) begin
                shadow[i] <= '0;
            end
        end else if (write_strobe) begin
            shadow[write_address] <= write_data;
        end
    end

    // Whole bank swaps at a period boundary
    always_ff @(posedge clock) begin
        if (!running || period_sync) begin
            active <= shadow;
        end
        // A stopped counter takes new values straight away
        if (write_strobe && !running) begin
            active[write_address] <= write_data;
        end
    end

    always_comb begin
        for (int i = 0; i < `PWM_N_CHANNELS; i++) begin
            low_threshold[i] = active[i];
            high_threshold[i] = active[i + `PWM_N_CHANNELS];
        end
    end

endmodule

// ==== pwm_timebase.sv ====
`include "pwm_config.svh"

module pwm_timebase (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          run,
    input  pwm_pkg::counter_mode_t        mode,
    input  logic [`PWM_COUNTER_WIDTH-1:0] start_value,
    input  logic [`PWM_COUNTER_WIDTH-1:0] stop_value,
    input  logic [15:0]                   shift,
    output logic [`PWM_COUNTER_WIDTH-1:0] count,
    output logic                          running,
    output logic                          period_sync
);
    import pwm_pkg::*;

    logic                          going_down;
    logic [`PWM_COUNTER_WIDTH-1:0] first_value;

    // Phase-shifted load value for the first period
    assign first_value = start_value + `PWM_COUNTER_WIDTH'(shift);

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
            running <= 1'b0;
            period_sync <= 1'b0;
            going_down <= 1'b0;
        end else begin
            period_sync <= 1'b0;
            if (!run) begin
                running <= 1'b0;
            end else if (!running) begin
                running <= 1'b1;
                count <= first_value;
                going_down <= 1'b0;
            end else begin
                case (mode)
                    count_down: begin
                        if (count <= start_value) begin
                            count <= stop_value;
                            period_sync <= 1'b1;
                        end else begin
                            count <= count - 1'b1;
                        end
                    end
                    count_updown: begin
                        if (going_down) begin
                            if (count <= start_value) begin
                                going_down <= 1'b0;
                                count <= count + 1'b1;
                            end else begin
                                count <= count - 1'b1;
                                // Period starts when the count lands on start
                                period_sync <= (count == start_value + 1'b1);
                            end
                        end else if (count >= stop_value) begin
                            going_down <= 1'b1;
                            count <= count - 1'b1;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                    default: begin
                        if (count >= stop_value) begin
                            count <= start_value;
                            period_sync <= 1'b1;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

// ==== pwm_channel.sv ====
`include "pwm_config.svh"

module pwm_channel (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [`PWM_COUNTER_WIDTH-1:0] count,
    input  logic [`PWM_COUNTER_WIDTH-1:0] low_threshold,
    input  logic [`PWM_COUNTER_WIDTH-1:0] high_threshold,
    input  logic [15:0]                   deadtime,
    input  logic                          deadtime_enable,
    input  logic [1:0]                    output_enable,
    output logic                          pwm_high,
    output logic                          pwm_low
);
    logic        raw;
    logic        raw_next;
    logic [15:0] dead_count;
    logic        settled;

    // Window check, high inside [low, high)
    assign raw_next = (count >= low_threshold) && (count < high_threshold);

    always_ff @(posedge clock) begin
        if (!reset) begin
            raw <= 1'b0;
            dead_count <= '0;
        end else begin
            raw <= raw_next;
            // Every raw edge restarts the dead time
            if (raw_next != raw) begin
                dead_count <= deadtime;
            end else if (dead_count != '0) begin
                dead_count <= dead_count - 1'b1;
            end
        end
    end

    // Turn-on waits for the count, turn-off is immediate
    assign settled = !deadtime_enable || (dead_count == '0);

    assign pwm_high = output_enable[0] && raw && settled;
    assign pwm_low = output_enable[1] && !raw && settled;

endmodule

// ==== pwm_chain.sv ====
`include "pwm_config.svh"

module pwm_chain (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          write_strobe,
    input  logic [31:0]                   address,
    input  logic [31:0]                   write_data,
    output logic                          ready,
    output logic [`PWM_COUNTER_WIDTH-1:0] count,
    output logic                          running,
    output logic                          period_sync,
    output logic                          pwm_high [`PWM_N_CHANNELS],
    output logic                          pwm_low [`PWM_N_CHANNELS]
);
    import pwm_pkg::*;

    logic                          counter_run;
    counter_mode_t                 counter_mode;
    logic [`PWM_COUNTER_WIDTH-1:0] start_value;
    logic [`PWM_COUNTER_WIDTH-1:0] stop_value;
    logic [15:0]                   timebase_shift;
    logic                          compare_write_strobe;
    compare_index_t                compare_address;
    logic [`PWM_COUNTER_WIDTH-1:0] compare_data;
    logic [15:0]                   deadtime [`PWM_N_CHANNELS];
    logic                          deadtime_enable [`PWM_N_CHANNELS];
    logic [1:0]                    output_enable [`PWM_N_CHANNELS];
    logic [`PWM_COUNTER_WIDTH-1:0] low_threshold [`PWM_N_CHANNELS];
    logic [`PWM_COUNTER_WIDTH-1:0] high_threshold [`PWM_N_CHANNELS];

    pwm_chain_control u_control (
        .clock                (clock),
        .reset                (reset),
        .write_strobe         (write_strobe),
        .address              (address),
        .write_data           (write_data),
        .counter_running      (running),
        .ready                (ready),
        .counter_run          (counter_run),
        .counter_mode         (counter_mode),
        .start_value          (start_value),
        .stop_value           (stop_value),
        .timebase_shift       (timebase_shift),
        .compare_write_strobe (compare_write_strobe),
        .compare_address      (compare_address),
        .compare_data         (compare_data),
        .deadtime             (deadtime),
        .deadtime_enable      (deadtime_enable),
        .output_enable        (output_enable)
    );

    pwm_timebase u_timebase (
        .clock       (clock),
        .reset       (reset),
        .run         (counter_run),
        .mode        (counter_mode),
        .start_value (start_value),
        .stop_value  (stop_value),
        .shift       (timebase_shift),
        .count       (count),
        .running     (running),
        .period_sync (period_sync)
    );

    pwm_compare_bank u_compare_bank (
        .clock          (clock),
        .reset          (reset),
        .write_strobe   (compare_write_strobe),
        .write_address  (compare_address),
        .write_data     (compare_data),
        .running        (running),
        .period_sync    (period_sync),
        .low_threshold  (low_threshold),
        .high_threshold (high_threshold)
    );

    // One output pair per channel
    for (genvar i = 0; i < `PWM_N_CHANNELS; i++) begin : gen_channel
        pwm_channel u_channel (
            .clock           (clock),
            .reset           (reset),
            .count           (count),
            .low_threshold   (low_threshold[i]),
            .high_threshold  (high_threshold[i]),
            .deadtime        (deadtime[i]),
            .deadtime_enable (deadtime_enable[i]),
            .output_enable   (output_enable[i]),
            .pwm_high        (pwm_high[i]),
            .pwm_low         (pwm_low[i])
        );
    end

endmodule

// ==== tb_pwm_chain.sv ====
`include "pwm_config.svh"

module tb_pwm_chain;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N = `PWM_N_CHANNELS;

    logic        clock;
    logic        reset;
    logic        write_strobe;
    logic [31:0] address;
    logic [31:0] write_data;
    logic        ready;
    logic [15:0] count;
    logic        running;
    logic        period_sync;
    logic        pwm_high [N];
    logic        pwm_low [N];

    // Reference model state
    integer      seed;
    int          fail_count;
    logic [1:0]  bus_phase;
    logic [31:0] m_addr;
    logic [31:0] m_data;
    logic        cmp_pend;
    logic [2:0]  cmp_idx;
    logic [15:0] cmp_val;
    logic [15:0] m_start;
    logic [15:0] m_stop;
    logic [15:0] m_shift;
    logic [15:0] m_top;
    logic [2:0]  m_mode;
    logic        m_dc;
    logic        m_run;
    logic        m_running;
    logic [15:0] m_dt [N];
    logic        m_dten [N];
    logic [1:0]  m_oe [N];
    logic [15:0] m_shadow [8];
    logic [15:0] m_active [8];
    logic        m_track;
    logic        m_down;
    logic        m_sync;
    logic [15:0] m_count;
    logic        m_raw [N];
    logic [15:0] m_dcnt [N];
    logic        exp_high [N];
    logic        exp_low [N];
    int          gap;
    logic        have_prev;

    pwm_chain dut0 (
        .clock        (clock),
        .reset        (reset),
        .write_strobe (write_strobe),
        .address      (address),
        .write_data   (write_data),
        .ready        (ready),
        .count        (count),
        .running      (running),
        .period_sync  (period_sync),
        .pwm_high     (pwm_high),
        .pwm_low      (pwm_low)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic value_error(string name, longint expected, longint actual);
        fail_count++;
        $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        $display("Simulation FAILED");
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic abort_run(string reason);
        fail_count++;
        $display("%0t %s", $time, reason);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [1:0] eff_mode();
        return (m_mode == 3'd1) ? 2'd1 : (m_mode == 3'd2) ? 2'd2 : 2'd0;
    endfunction

    function automatic int period_cycles();
        int span;
        span = int'(m_stop) - int'(m_start);
        return (eff_mode() == 2'd2) ? 2 * span : span + 1;
    endfunction

    // Next {sync, down, count} from the counting rules
    function automatic logic [17:0] next_state(logic [15:0] c, logic down);
        case (eff_mode())
            2'd1: begin
                if (c == m_start) return {2'b10, m_stop};
                return {2'b00, c - 16'd1};
            end
            2'd2: begin
                if (down && c == m_start) return {2'b00, c + 16'd1};
                if (down) return {(c - 16'd1) == m_start, 1'b1, c - 16'd1};
                if (c == m_stop) return {2'b01, c - 16'd1};
                return {2'b00, c + 16'd1};
            end
            default: begin
                if (c == m_stop) return {2'b10, m_start};
                return {2'b00, c + 16'd1};
            end
        endcase
    endfunction

    always @(posedge clock) begin
        logic [17:0] nxt;
        logic [15:0] cur;
        logic [15:0] d;
        logic [31:0] off;
        logic        win;
        cur = (running && m_track) ? m_count : count;
        off = m_addr - `PWM_BASE_ADDRESS;
        d = m_data[15:0];
        if (!reset) begin
            bus_phase <= 2'd0;
            cmp_pend <= 1'b0;
            m_start <= '0;
            m_stop <= '0;
            m_shift <= '0;
            m_top <= '1;
            m_mode <= '0;
            m_dc <= 1'b0;
            m_run <= 1'b0;
            m_running <= 1'b0;
            m_track <= 1'b0;
            have_prev <= 1'b0;
            gap <= 0;
            for (int k = 0; k < 8; k++) begin
                m_shadow[k] <= '0;
                m_active[k] <= '0;
            end
            for (int k = 0; k < N; k++) begin
                m_dt[k] <= '0;
                m_dten[k] <= 1'b0;
                m_oe[k] <= 2'b00;
                m_raw[k] <= 1'b0;
                m_dcnt[k] <= '0;
            end
        end else begin
            // Bus slave: accept, decode, release
            cmp_pend <= 1'b0;
            // Timebase follows the run bit one cycle later
            m_running <= m_run;
            if (bus_phase == 2'd0 && write_strobe) begin
                bus_phase <= 2'd1;
                m_addr <= address;
                m_data <= write_data;
            end else if (bus_phase == 2'd1) begin
                bus_phase <= 2'd2;
                for (int k = 0; k < N; k++) begin
                    if (off == `PWM_REG_CMP_LOW0 + 4 * k) begin
                        cmp_pend <= 1'b1;
                        cmp_idx <= 3'(k);
                        cmp_val <= d;
                    end
                    if (off == `PWM_REG_CMP_HIGH0 + 4 * k) begin
                        cmp_pend <= 1'b1;
                        cmp_idx <= 3'(k + 3);
                        cmp_val <= m_dc ? m_top - d : d;
                    end
                    if (off == `PWM_REG_DEADTIME0 + 4 * k && !running) m_dt[k] <= d;
                    if (off == `PWM_REG_OUT_EN) m_oe[k] <= m_data[2*k +: 2];
                    if (off == `PWM_REG_DT_EN) m_dten[k] <= m_data[k];
                end
                if (off == `PWM_REG_START && !running) m_start <= d;
                if (off == `PWM_REG_STOP && !running) begin
                    m_stop <= d;
                    if (m_dc) m_top <= d;
                end
                if (off == `PWM_REG_SHIFT && !running) m_shift <= d;
                if (off == `PWM_REG_CONTROL) m_run <= m_data[4];
                if (off == `PWM_REG_CONTROL && !running) begin
                    m_dc <= m_data[3];
                    m_mode <= m_data[3] ? 3'd2 : m_data[2:0];
                end
            end else begin
                bus_phase <= 2'd0;
            end
            // Thresholds swap at the period boundary or at once when stopped
            for (int k = 0; k < 8; k++) begin
                if (!running || period_sync) m_active[k] <= m_shadow[k];
            end
            if (cmp_pend) begin
                m_shadow[cmp_idx] <= cmp_val;
                if (!running) m_active[cmp_idx] <= cmp_val;
            end
            // First running cycle adopts the count, then the model steps alone
            if (!running) begin
                m_track <= 1'b0;
                have_prev <= 1'b0;
            end else begin
                nxt = next_state(cur, m_track && m_down);
                m_track <= 1'b1;
                m_count <= nxt[15:0];
                m_down <= nxt[16];
                m_sync <= nxt[17];
                if (period_sync) have_prev <= 1'b1;
                gap <= period_sync ? 1 : gap + 1;
            end
            for (int k = 0; k < N; k++) begin
                win = (cur >= m_active[k]) && (cur < m_active[k + 3]);
                m_raw[k] <= win;
                if (win != m_raw[k]) m_dcnt[k] <= m_dt[k];
                else if (m_dcnt[k] != '0) m_dcnt[k] <= m_dcnt[k] - 16'd1;
            end
        end
    end

    always_comb begin
        for (int k = 0; k < N; k++) begin
            exp_high[k] = m_oe[k][0] && m_raw[k] && (!m_dten[k] || m_dcnt[k] == '0);
            exp_low[k] = m_oe[k][1] && !m_raw[k] && (!m_dten[k] || m_dcnt[k] == '0);
        end
    end

    assert property (@(posedge clock) $rose(reset) |-> {ready, running, period_sync} == 3'b100)
        else value_error("ready/running/period_sync", 3'b100,
                         $sampled({ready, running, period_sync}));
    assert property (@(posedge clock) disable iff (!reset) ready == (bus_phase == 2'd0))
        else value_error("ready", $sampled(bus_phase == 2'd0), $sampled(ready));
    assert property (@(posedge clock) disable iff (!reset) running == m_running)
        else value_error("running", $sampled(m_running), $sampled(running));
    assert property (@(posedge clock) disable iff (!reset)
        running && !m_track |-> count == m_start + m_shift)
        else value_error("count", $sampled(m_start + m_shift), $sampled(count));
    assert property (@(posedge clock) disable iff (!reset)
        running && m_track |-> count == m_count)
        else value_error("count", $sampled(m_count), $sampled(count));
    assert property (@(posedge clock) disable iff (!reset)
        period_sync == (running && m_track && m_sync))
        else value_error("period_sync", $sampled(running && m_track && m_sync),
                         $sampled(period_sync));
    assert property (@(posedge clock) disable iff (!reset)
        period_sync && have_prev |-> gap == period_cycles())
        else value_error("period length", $sampled(period_cycles()), $sampled(gap));

    for (genvar k = 0; k < N; k++) begin : gen_check
        assert property (@(posedge clock) disable iff (!reset) pwm_high[k] == exp_high[k])
            else value_error($sformatf("pwm_high[%0d]", k), $sampled(exp_high[k]),
                             $sampled(pwm_high[k]));
        assert property (@(posedge clock) disable iff (!reset) pwm_low[k] == exp_low[k])
            else value_error($sformatf("pwm_low[%0d]", k), $sampled(exp_low[k]),
                             $sampled(pwm_low[k]));
        assert property (@(posedge clock) disable iff (!reset) !(pwm_high[k] && pwm_low[k]))
            else abort_run($sformatf("both outputs of channel %0d high together", k));
    end

    function automatic int rand_below(int n);
        int r;
        r = $random(seed);
        if (r < 0) r = -r;
        return r % n;
    endfunction

    task automatic wait_ready();
        int t;
        t = 0;
        while (!ready) begin
            @(posedge clock);
            t++;
            if (t > 50) abort_run("ready did not return after a bus write");
        end
    endtask

    // Optional stray strobe on the busy cycle must be ignored
    task automatic bus_write(logic [31:0] off, logic [31:0] data, bit stray = 1'b0);
        wait_ready();
        write_strobe <= 1'b1;
        address <= `PWM_BASE_ADDRESS + off;
        write_data <= data;
        @(posedge clock);
        write_strobe <= stray;
        address <= `PWM_BASE_ADDRESS + `PWM_REG_OUT_EN;
        write_data <= '0;
        @(posedge clock);
        write_strobe <= 1'b0;
        wait_ready();
    endtask

    task automatic wait_syncs(int n);
        int seen;
        int t;
        seen = 0;
        t = 0;
        while (seen < n) begin
            @(posedge clock);
            if (period_sync) seen++;
            t++;
            if (t > 5000) abort_run("period_sync pulses stopped arriving");
        end
    endtask

    task automatic stop_counter(logic [31:0] control);
        int t;
        bus_write(`PWM_REG_CONTROL, control);
        t = 0;
        while (running) begin
            @(posedge clock);
            t++;
            if (t > 20) abort_run("counter kept running after run was cleared");
        end
    endtask

    task automatic random_windows(int start, int len);
        int lo;
        for (int k = 0; k < N; k++) begin
            lo = start + rand_below(len);
            bus_write(`PWM_REG_CMP_LOW0 + 4 * k, 32'(lo));
            bus_write(`PWM_REG_CMP_HIGH0 + 4 * k, 32'(lo + 1 + rand_below(len)));
        end
    endtask

    task automatic run_mode(logic [31:0] control, bit with_deadtime);
        int start;
        int len;
        start = rand_below(256);
        len = 6 + rand_below(32);
        bus_write(`PWM_REG_START, 32'(start));
        bus_write(`PWM_REG_STOP, 32'(start + len));
        bus_write(`PWM_REG_SHIFT, 32'(rand_below(len)));
        for (int k = 0; k < N; k++) begin
            bus_write(`PWM_REG_DEADTIME0 + 4 * k, with_deadtime ? 32'(k + 1) : 32'd0);
        end
        random_windows(start, len);
        bus_write(`PWM_REG_CONTROL, control | 32'h10);
        wait_syncs(3);
        // New windows while running wait for the next boundary
        random_windows(start, len);
        wait_syncs(3);
        stop_counter(control);
    endtask

    initial begin
        seed = 32'he4d0a22d;
        fail_count = 0;
        reset <= 1'b0;
        write_strobe <= 1'b0;
        address <= '0;
        write_data <= '0;
        repeat (16) @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);
        bus_write(`PWM_REG_OUT_EN, 32'h3F, 1'b1);
        bus_write(`PWM_REG_DT_EN, 32'h0, 1'b1);
        for (int m = 0; m < 3; m++) begin
            bus_write(`PWM_REG_CONTROL, 32'(m));
            run_mode(32'(m), 1'b0);
        end
        // Duty-cycle mode with writes that must be ignored while running
        bus_write(`PWM_REG_CONTROL, 32'h08);
        bus_write(`PWM_REG_START, 32'd10);
        bus_write(`PWM_REG_STOP, 32'd40);
        bus_write(`PWM_REG_SHIFT, 32'd4);
        // Channel 0 dead time enabled at zero
        bus_write(`PWM_REG_DT_EN, 32'h1);
        for (int k = 0; k < N; k++) begin
            bus_write(`PWM_REG_CMP_LOW0 + 4 * k, 32'd10);
            bus_write(`PWM_REG_CMP_HIGH0 + 4 * k, 32'(5 + 6 * k));
        end
        bus_write(`PWM_REG_CONTROL, 32'h18);
        wait_syncs(2);
        bus_write(`PWM_REG_START, 32'd3);
        bus_write(`PWM_REG_STOP, 32'd90);
        bus_write(`PWM_REG_DEADTIME0, 32'd7);
        bus_write(`PWM_REG_CMP_HIGH1, 32'd20);
        wait_syncs(3);
        stop_counter(32'h08);
        bus_write(`PWM_REG_CONTROL, 32'h0);
        // Dead time on, channel 1 high side and channel 2 low side gated
        bus_write(`PWM_REG_DT_EN, 32'h7);
        bus_write(`PWM_REG_OUT_EN, 32'h1B);
        run_mode(32'h0, 1'b1);
        run_mode(32'h2, 1'b1);
        if (fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

// ==== sim.f ====
+incdir+.
pwm_pkg.sv
pwm_chain_control.sv
pwm_compare_bank.sv
pwm_timebase.sv
pwm_channel.sv
pwm_chain.sv
tb_pwm_chain.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PWM chain testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_pwm_chain -f sim.f -o tb_pwm_chain
./obj_dir/tb_pwm_chain
